// File: src/cic_decim_consts.svh
// CIC decimator constants
`ifndef CIC_DECIM_CONSTS_SVH
`define CIC_DECIM_CONSTS_SVH

// integrator and comb stage count, differential delay is one
`define CIC_STAGES 3

// sample widths at the filter ports
`define CIC_IN_WIDTH 16
`define CIC_OUT_WIDTH 16

// largest rate exponent, rate 64
`define CIC_MAX_LOG2_RATE 6

// accumulator sized for full bit growth at the largest rate
`define CIC_ACC_WIDTH (`CIC_IN_WIDTH + `CIC_STAGES * `CIC_MAX_LOG2_RATE)

// APB byte addresses
`define CIC_ADDR_CTRL 32'h0000_0000
`define CIC_ADDR_STATUS 32'h0000_0004

`endif

// File: src/cic_decim_pkg.sv
// CIC decimator types
`include "cic_decim_consts.svh"

package cic_decim_pkg;

	// signed sample at the filter input and output
	typedef logic signed [`CIC_IN_WIDTH-1:0] sample_t;

	// signed accumulator word, wraps modulo 2^ACC_WIDTH
	typedef logic signed [`CIC_ACC_WIDTH-1:0] acc_t;

	// control register fields, top bit first
	typedef struct packed
	{
		logic [26:0] reserved;
		logic enable;
		// decimation rate is 2^log2_rate
		logic [3:0] log2_rate;
	} ctrl_fields_t;

	// control register as seen on the bus and as fields
	typedef union packed
	{
		logic [31:0] raw;
		ctrl_fields_t fields;
	} ctrl_word_u;

endpackage

// File: src/cic_apb_regs.sv
// CIC APB register block
`timescale 1ns/1ps
`include "cic_decim_consts.svh"

module cic_apb_regs (
	input  logic        clock,
	input  logic        rst_n,
	input  logic [31:0] paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic        out_valid,
	output logic [3:0]  log2_rate,
	output logic        enable,
	output logic        clear
);

	logic access;
	logic addr_ctrl;
	logic addr_status;
	logic rate_bad;
	logic slv_err;
	logic ctrl_wr;
	logic [15:0] out_count;
	cic_decim_pkg::ctrl_word_u wr_word;
	cic_decim_pkg::ctrl_word_u ctrl_q;

	// no wait states
	assign pready = 1'b1;
	assign access = psel && penable;

	assign addr_ctrl = (paddr == `CIC_ADDR_CTRL);
	assign addr_status = (paddr == `CIC_ADDR_STATUS);

	// write data decoded as control fields
	assign wr_word.raw = pwdata;
	assign rate_bad = (wr_word.fields.log2_rate > 4'(`CIC_MAX_LOG2_RATE));

	always_comb
	begin
		slv_err = 1'b0;
		if (!addr_ctrl && !addr_status)
			slv_err = 1'b1;
		else if (pwrite && addr_status)
			slv_err = 1'b1;
		else if (pwrite && addr_ctrl && rate_bad)
			slv_err = 1'b1;
	end

	// error only in the access phase
	assign pslverr = access && slv_err;
	assign ctrl_wr = access && pwrite && addr_ctrl && !rate_bad;

	always_comb
	begin
		prdata = '0;
		if (psel && !pwrite)
		begin
			if (addr_ctrl)
				prdata = ctrl_q.raw;
			else if (addr_status)
				prdata = 32'(out_count);
		end
	end

	// reserved bits always stored as zero
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ctrl_q <= '0;
			clear <= 1'b0;
		end
		else
		begin
			clear <= ctrl_wr;
			if (ctrl_wr)
				ctrl_q.fields <= '{
					reserved: '0,
					enable: wr_word.fields.enable,
					log2_rate: wr_word.fields.log2_rate
				};
		end
	end

	// output samples since the last accepted control write
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			out_count <= '0;
		else if (clear)
			out_count <= '0;
		else if (out_valid)
			out_count <= out_count + 1'b1;
	end

	assign log2_rate = ctrl_q.fields.log2_rate;
	assign enable = ctrl_q.fields.enable;

endmodule

// File: src/cic_integrators.sv
// CIC integrator chain
`timescale 1ns/1ps
`include "cic_decim_consts.svh"

module cic_integrators (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  clear,
	input  logic                  in_valid,
	input  cic_decim_pkg::sample_t in_data,
	input  logic [3:0]            log2_rate,
	output logic                  integ_valid,
	output cic_decim_pkg::acc_t   integ_data
);

	logic pre_valid;
	cic_decim_pkg::acc_t pre_data;
	logic [4:0] shift;
	logic [`CIC_STAGES-1:0] stage_valid;
	cic_decim_pkg::acc_t acc [`CIC_STAGES];

	// growth of the selected rate lands in the top bits of the accumulator
	assign shift = 5'(`CIC_STAGES) * (5'(`CIC_MAX_LOG2_RATE) - 5'(log2_rate));

	// pre-shift stage keeps running through a clear so a sample
	// arriving with the clear pulse still enters the new block
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			pre_valid <= 1'b0;
		else
			pre_valid <= in_valid;
	end

	always_ff @(posedge clock)
	begin
		if (in_valid)
			pre_data <= cic_decim_pkg::acc_t'(in_data) <<< shift;
	end

	// each stage advances one cycle after the stage before it
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			stage_valid <= '0;
			for (int i = 0; i < `CIC_STAGES; i++)
				acc[i] <= '0;
		end
		else if (clear)
		begin
			stage_valid <= '0;
			for (int i = 0; i < `CIC_STAGES; i++)
				acc[i] <= '0;
		end
		else
		begin
			stage_valid <= {stage_valid[`CIC_STAGES-2:0], pre_valid};
			// accumulators wrap, the combs undo it
			if (pre_valid)
				acc[0] <= acc[0] + pre_data;
			for (int i = 1; i < `CIC_STAGES; i++)
			begin
				if (stage_valid[i-1])
					acc[i] <= acc[i] + acc[i-1];
			end
		end
	end

	assign integ_valid = stage_valid[`CIC_STAGES-1];
	assign integ_data = acc[`CIC_STAGES-1];

endmodule

// File: src/cic_combs.sv
// CIC comb chain
`timescale 1ns/1ps
`include "cic_decim_consts.svh"

module cic_combs (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   clear,
	input  logic                   dump_valid,
	input  cic_decim_pkg::acc_t    integ_data,
	output logic                   out_valid,
	output cic_decim_pkg::sample_t out_data
);

	logic [`CIC_STAGES-1:0] comb_valid;
	cic_decim_pkg::acc_t comb [`CIC_STAGES];
	// previous input of each stage, differential delay of one
	cic_decim_pkg::acc_t dly [`CIC_STAGES];

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			comb_valid <= '0;
			out_valid <= 1'b0;
			for (int i = 0; i < `CIC_STAGES; i++)
			begin
				comb[i] <= '0;
				dly[i] <= '0;
			end
		end
		else if (clear)
		begin
			comb_valid <= '0;
			out_valid <= 1'b0;
			for (int i = 0; i < `CIC_STAGES; i++)
			begin
				comb[i] <= '0;
				dly[i] <= '0;
			end
		end
		else
		begin
			comb_valid <= {comb_valid[`CIC_STAGES-2:0], dump_valid};
			out_valid <= comb_valid[`CIC_STAGES-1];
			// first stage only moves on dump samples
			if (dump_valid)
			begin
				comb[0] <= integ_data - dly[0];
				dly[0] <= integ_data;
			end
			for (int i = 1; i < `CIC_STAGES; i++)
			begin
				if (comb_valid[i-1])
				begin
					comb[i] <= comb[i-1] - dly[i];
					dly[i] <= comb[i-1];
				end
			end
		end
	end

	// top bits of the last comb give unity DC gain at every rate
	always_ff @(posedge clock)
	begin
		if (comb_valid[`CIC_STAGES-1])
			out_data <= comb[`CIC_STAGES-1][`CIC_ACC_WIDTH-1 -: `CIC_OUT_WIDTH];
	end

endmodule

// File: src/cic_decimator.sv
// CIC decimator core
`timescale 1ns/1ps
`include "cic_decim_consts.svh"

module cic_decimator (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   clear,
	input  logic                   enable,
	input  logic [3:0]             log2_rate,
	input  logic                   in_valid,
	input  cic_decim_pkg::sample_t in_data,
	output logic                   out_valid,
	output cic_decim_pkg::sample_t out_data
);

	logic accepted;
	logic integ_valid;
	cic_decim_pkg::acc_t integ_data;
	logic dump_valid;
	logic [`CIC_MAX_LOG2_RATE-1:0] rate_cnt;
	logic [`CIC_MAX_LOG2_RATE-1:0] last_cnt;

	// samples are dropped while disabled
	assign accepted = in_valid && enable;

	cic_integrators i_cic_integrators (
		.clock       (clock),
		.rst_n       (rst_n),
		.clear       (clear),
		.in_valid    (accepted),
		.in_data     (in_data),
		.log2_rate   (log2_rate),
		.integ_valid (integ_valid),
		.integ_data  (integ_data)
	);

	// last count of a block is 2^log2_rate - 1
	assign last_cnt = ~({`CIC_MAX_LOG2_RATE{1'b1}} << log2_rate);

	// every 2^log2_rate-th integrator output is kept
	assign dump_valid = integ_valid && (rate_cnt == last_cnt);

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			rate_cnt <= '0;
		else if (clear)
			rate_cnt <= '0;
		else if (integ_valid)
		begin
			if (rate_cnt == last_cnt)
				rate_cnt <= '0;
			else
				rate_cnt <= rate_cnt + 1'b1;
		end
	end

	// combs run at the decimated rate
	cic_combs i_cic_combs (
		.clock      (clock),
		.rst_n      (rst_n),
		.clear      (clear),
		.dump_valid (dump_valid),
		.integ_data (integ_data),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

endmodule

// File: src/cic_decim_top.sv
// CIC decimator top level
`timescale 1ns/1ps

module cic_decim_top (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic [31:0]            paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   in_valid,
	input  cic_decim_pkg::sample_t in_data,
	output logic                   out_valid,
	output cic_decim_pkg::sample_t out_data
);

	logic [3:0] log2_rate;
	logic enable;
	logic clear;

	// control and status registers
	cic_apb_regs i_cic_apb_regs (
		.clock     (clock),
		.rst_n     (rst_n),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.out_valid (out_valid),
		.log2_rate (log2_rate),
		.enable    (enable),
		.clear     (clear)
	);

	// filter datapath
	cic_decimator i_cic_decimator (
		.clock     (clock),
		.rst_n     (rst_n),
		.clear     (clear),
		.enable    (enable),
		.log2_rate (log2_rate),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// File: verification/cic_decim_tb.sv
// CIC decimator testbench
`timescale 1ns/1ps
`include "cic_decim_consts.svh"

module cic_decim_tb;

	logic clock;
	logic rst_n;
	logic [31:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic in_valid;
	cic_decim_pkg::sample_t in_data;
	logic out_valid;
	cic_decim_pkg::sample_t out_data;

	// rows of rate exponent, DC input and block count
	// at unity gain the DC input is also the expected output
	int row_rate [5] = '{0, 1, 3, 6, 4};
	int row_dc [5] = '{1234, -500, 32767, -32768, 7};
	int row_blocks [5] = '{20, 12, 10, 8, 10};

	// output monitor state
	int cyc = 0;
	int out_cnt = 0;
	int exp_dc = 0;
	bit chk_on = 1'b0;
	bit lat_on = 1'b0;
	int lat_q [$];
	logic [31:0] rng_state = 32'd56698;

	cic_decim_top i_cic_decim_top (
		.clock     (clock),
		.rst_n     (rst_n),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// cycle number as seen by the falling edge monitor
	always @(posedge clock)
		cyc = cyc + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input longint expected, input longint actual);
		if (expected !== actual)
			abort_run($sformatf("ERROR at %0d ns: %s expected %0d actual %0d",
				$time, name, expected, actual));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
		input logic exp_err);
		int t;
		@(negedge clock);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clock);
		penable = 1'b1;
		#1;
		t = 0;
		while (pready !== 1'b1)
		begin
			@(negedge clock);
			#1;
			t++;
			if (t > 16)
				abort_run("timeout: pready never rose during an APB write");
		end
		check("pslverr", longint'(exp_err), longint'(pslverr));
		@(negedge clock);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [31:0] addr, input logic exp_err,
		output logic [31:0] data);
		int t;
		@(negedge clock);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clock);
		penable = 1'b1;
		#1;
		t = 0;
		while (pready !== 1'b1)
		begin
			@(negedge clock);
			#1;
			t++;
			if (t > 16)
				abort_run("timeout: pready never rose during an APB read");
		end
		check("pslverr", longint'(exp_err), longint'(pslverr));
		data = prdata;
		@(negedge clock);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// drives n samples of one DC value with idle gaps of 0 to 3 cycles when gaps is set
	task automatic drive_samples(input int n, input int dc, input bit gaps, input int blk);
		int gap;
		for (int i = 0; i < n; i++)
		begin
			@(negedge clock);
			in_valid = 1'b1;
			in_data = cic_decim_pkg::sample_t'(dc);
			// result of the block that ends here is due 8 cycles later
			if (lat_on && ((i + 1) % blk == 0))
				lat_q.push_back(cyc + 8);
			gap = 0;
			if (gaps)
			begin
				rng_state = xorshift32(rng_state);
				gap = {30'b0, rng_state[1:0]};
			end
			repeat (gap)
			begin
				@(negedge clock);
				in_valid = 1'b0;
			end
		end
		@(negedge clock);
		in_valid = 1'b0;
	endtask

	task automatic wait_for_outputs(input int n);
		int t;
		t = 0;
		while (out_cnt < n)
		begin
			@(negedge clock);
			t++;
			if (t > 500)
				abort_run("timeout: expected output samples did not arrive");
		end
	endtask

	task automatic run_row(input int k, input int dc, input int blocks, input bit gaps);
		cic_decim_pkg::ctrl_word_u w;
		logic [31:0] data;
		w.raw = '0;
		w.fields.enable = 1'b1;
		w.fields.log2_rate = 4'(k);
		out_cnt = 0;
		exp_dc = dc;
		chk_on = 1'b1;
		apb_write(`CIC_ADDR_CTRL, w.raw, 1'b0);
		drive_samples(blocks << k, dc, gaps, 1 << k);
		wait_for_outputs(blocks);
		// long enough for any stray result to show up
		repeat (16) @(negedge clock);
		check("out_valid count", longint'(blocks), longint'(out_cnt));
		apb_read(`CIC_ADDR_STATUS, 1'b0, data);
		check("STATUS", longint'(blocks), longint'(data));
		chk_on = 1'b0;
	endtask

	// outputs are stable on the falling edge
	always @(negedge clock)
	begin
		if (out_valid)
		begin
			// first results of a block run hold start-up transients
			if (chk_on && out_cnt >= 3)
				check("out_data", longint'(exp_dc), longint'(out_data));
			if (lat_on)
			begin
				if (lat_q.size() == 0)
					abort_run("out_valid seen with no completed input block");
				else
					check("out_valid cycle", longint'(lat_q.pop_front()), longint'(cyc));
			end
			out_cnt++;
		end
	end

	initial
	begin
		cic_decim_pkg::ctrl_word_u w;
		cic_decim_pkg::ctrl_word_u good;
		logic [31:0] data;
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		in_valid = 1'b0;
		in_data = '0;
		repeat (5) @(negedge clock);
		rst_n = 1'b1;

		// reset state
		repeat (10)
		begin
			@(negedge clock);
			check("out_valid", 0, longint'(out_valid));
		end
		apb_read(`CIC_ADDR_CTRL, 1'b0, data);
		check("CTRL", 0, longint'(data));
		apb_read(`CIC_ADDR_STATUS, 1'b0, data);
		check("STATUS", 0, longint'(data));

		// APB error responses
		apb_write(32'h0000_0008, 32'h0000_0011, 1'b1);
		apb_read(32'h0000_0008, 1'b1, data);
		apb_write(`CIC_ADDR_STATUS, 32'h0000_0005, 1'b1);
		good.raw = '0;
		good.fields.enable = 1'b1;
		good.fields.log2_rate = 4'd2;
		apb_write(`CIC_ADDR_CTRL, good.raw, 1'b0);
		apb_read(`CIC_ADDR_CTRL, 1'b0, data);
		check("CTRL", longint'(good.raw), longint'(data));
		w = good;
		w.fields.log2_rate = 4'd7;
		apb_write(`CIC_ADDR_CTRL, w.raw, 1'b1);
		apb_read(`CIC_ADDR_CTRL, 1'b0, data);
		check("CTRL", longint'(good.raw), longint'(data));

		// samples are ignored while disabled
		w.raw = '0;
		w.fields.log2_rate = 4'd2;
		apb_write(`CIC_ADDR_CTRL, w.raw, 1'b0);
		out_cnt = 0;
		drive_samples(40, 321, 1'b0, 4);
		repeat (20) @(negedge clock);
		check("out_valid count", 0, longint'(out_cnt));
		apb_read(`CIC_ADDR_STATUS, 1'b0, data);
		check("STATUS", 0, longint'(data));

		for (int r = 0; r < 5; r++)
			run_row(row_rate[r], row_dc[r], row_blocks[r], 1'b1);

		// back-to-back samples at rate 8 for the fixed latency
		lat_q.delete();
		lat_on = 1'b1;
		run_row(3, 100, 6, 1'b0);
		lat_on = 1'b0;

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: cic_decim.f
+incdir+src
src/cic_decim_pkg.sv
src/cic_apb_regs.sv
src/cic_integrators.sv
src/cic_combs.sv
src/cic_decimator.sv
src/cic_decim_top.sv
verification/cic_decim_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the CIC decimator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module cic_decim_tb \
	-f cic_decim.f -o cic_decim_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/cic_decim_sim > sim.log 2>&1 || echo "simulator exited with an error status"

cat sim.log
grep -qF -- '*** PASSED ***' sim.log && echo "result: pass" && exit 0 \
	|| { echo "result: fail"; exit 1; }
